// File: udp_tx_cfg.svh
// UDP transmit framer configuration
// byte width, header sizes and length counter width

`ifndef UDP_TX_CFG_SVH
`define UDP_TX_CFG_SVH

// one stream byte
`define UDP_TX_BYTE_W 8

// UDP header bytes, counted in the UDP length field
`define UDP_TX_UDP_HDR_BYTES 8

// fixed IP header size added to form the IP total length
`define UDP_TX_IP_HDR_BYTES 20

// lengths and frame pointer
`define UDP_TX_LEN_W 16

`endif

// File: udp_tx_pkg.sv
// UDP transmit framer types
// IP and UDP header records and the payload stream beat

`default_nettype none

`include "udp_tx_cfg.svh"

package udp_tx_pkg;

    // IP header fields that pass through untouched
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_fields_t;

    // outgoing IP header with the computed total length
    typedef struct packed {
        ip_fields_t                  fields;
        logic [`UDP_TX_LEN_W-1:0]    ip_length;
    } ip_hdr_t;

    typedef struct packed {
        logic [15:0]              source_port;
        logic [15:0]              dest_port;
        logic [`UDP_TX_LEN_W-1:0] length;
        logic [15:0]              checksum;
    } udp_hdr_t;

    // same word as fields or as bytes in wire order, byte 0 first
    typedef union packed {
        udp_hdr_t                                                fields;
        logic [0:`UDP_TX_UDP_HDR_BYTES-1][`UDP_TX_BYTE_W-1:0]   bytes;
    } udp_hdr_u;

    typedef struct packed {
        logic [`UDP_TX_BYTE_W-1:0] data;
        logic                      last;
        logic                      user;
    } axis_beat_t;

endpackage

`default_nettype wire

// File: ip_hdr_reg.sv
// IP header register
// captures the pass-through IP fields on header accept, derives the
// IP total length and holds the header until the sink takes it

`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_cfg.svh"

module ip_hdr_reg (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       hdr_store,
    input  udp_tx_pkg::ip_fields_t     s_ip,
    input  logic [`UDP_TX_LEN_W-1:0]   s_udp_length,

    output logic                       m_hdr_valid,
    input  logic                       m_hdr_ready,
    output udp_tx_pkg::ip_hdr_t        m_ip,

    output logic                       hdr_pending
);

    localparam int LEN_W = `UDP_TX_LEN_W;
    localparam logic [LEN_W-1:0] IP_HDR_LEN = LEN_W'(`UDP_TX_IP_HDR_BYTES);

    // header valid until the sink handshakes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_hdr_valid <= 1'b0;
        end else if (hdr_store) begin
            m_hdr_valid <= 1'b1;
        end else if (m_hdr_ready) begin
            m_hdr_valid <= 1'b0;
        end
    end

    // header payload
    always_ff @(posedge clk) begin
        if (hdr_store) begin
            m_ip.fields    <= s_ip;
            // total length covers the UDP datagram plus the IP header
            m_ip.ip_length <= s_udp_length + IP_HDR_LEN;
        end
    end

    // framer holds off new headers while this one is outstanding
    assign hdr_pending = m_hdr_valid;

    // the framer must not overwrite a header the sink has not taken
    a_no_store_while_valid: assert property (
        @(posedge clk) disable iff (rst)
        hdr_store |-> !m_hdr_valid
    ) else $error("header stored while previous header still pending");

endmodule

`default_nettype wire

// File: udp_tx_ctrl.sv
// UDP framer control
// accepts the UDP header, serializes it byte by byte, then forwards the
// payload trimmed or flagged against the UDP length

`timescale 1ns/1ps
`default_nettype none

`include "udp_tx_cfg.svh"

module udp_tx_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  udp_tx_pkg::udp_hdr_t    s_udp,

    input  logic                    s_valid,
    output logic                    s_ready,
    input  udp_tx_pkg::axis_beat_t  s_beat,

    output logic                    hdr_store,
    input  logic                    hdr_pending,

    output logic                    int_valid,
    output udp_tx_pkg::axis_beat_t  int_beat,
    input  logic                    int_ready_early,

    output logic                    busy,
    output logic                    error_early_end
);

    import udp_tx_pkg::*;

    localparam int LEN_W     = `UDP_TX_LEN_W;
    localparam int HDR_BYTES = `UDP_TX_UDP_HDR_BYTES;
    localparam int HDR_IDX_W = $clog2(HDR_BYTES);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HEADER  = 2'd1;
    localparam logic [1:0] ST_PAYLOAD = 2'd2;
    localparam logic [1:0] ST_TRIM    = 2'd3;

    logic [1:0]                state;
    logic [1:0]                state_next;
    logic [LEN_W-1:0]          ptr;
    logic [LEN_W-1:0]          ptr_next;
    logic                      int_ready;
    logic                      save_byte;
    logic                      err_next;
    logic                      s_xfer;
    udp_hdr_u                  hdr_q;
    logic [`UDP_TX_BYTE_W-1:0] last_data;

    assign s_xfer = s_valid && s_ready;

    always_comb begin
        state_next = state;
        ptr_next   = ptr;
        hdr_store  = 1'b0;
        save_byte  = 1'b0;
        err_next   = 1'b0;
        int_valid  = 1'b0;
        int_beat   = '0;

        case (state)
            ST_IDLE: begin
                ptr_next = '0;
                if (s_hdr_valid && s_hdr_ready) begin
                    hdr_store  = 1'b1;
                    state_next = ST_HEADER;
                end
            end
            ST_HEADER: begin
                int_beat.data = hdr_q.bytes[ptr[HDR_IDX_W-1:0]];
                if (int_ready) begin
                    ptr_next = ptr + 1'b1;
                    if (ptr_next == hdr_q.fields.length) begin
                        // empty datagram, hold checksum byte until input last
                        save_byte  = 1'b1;
                        state_next = ST_TRIM;
                    end else begin
                        int_valid = 1'b1;
                        if (ptr == LEN_W'(HDR_BYTES - 1)) begin
                            state_next = ST_PAYLOAD;
                        end
                    end
                end
            end
            ST_PAYLOAD: begin
                int_beat  = s_beat;
                int_valid = s_xfer;
                if (s_xfer) begin
                    ptr_next = ptr + 1'b1;
                    if (s_beat.last) begin
                        if (ptr_next != hdr_q.fields.length) begin
                            // input ran short of the UDP length
                            int_beat.user = 1'b1;
                            err_next      = 1'b1;
                        end
                        state_next = ST_IDLE;
                    end else if (ptr_next == hdr_q.fields.length) begin
                        // hold final byte back until input last shows up
                        save_byte  = 1'b1;
                        int_valid  = 1'b0;
                        state_next = ST_TRIM;
                    end
                end
            end
            default: begin
                // discard surplus input, release saved byte on last
                int_beat.data = last_data;
                int_beat.last = s_beat.last;
                int_beat.user = s_beat.user;
                int_valid     = s_xfer && s_beat.last;
                if (s_xfer && s_beat.last) begin
                    state_next = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= ST_IDLE;
            ptr             <= '0;
            int_ready       <= 1'b0;
            s_ready         <= 1'b0;
            s_hdr_ready     <= 1'b0;
            busy            <= 1'b0;
            error_early_end <= 1'b0;
        end else begin
            state     <= state_next;
            ptr       <= ptr_next;
            int_ready <= int_ready_early;
            // input only flows while the frame body is being moved
            s_ready <= ((state_next == ST_PAYLOAD) || (state_next == ST_TRIM))
                       && int_ready_early;
            s_hdr_ready     <= (state_next == ST_IDLE) && !hdr_pending;
            busy            <= state_next != ST_IDLE;
            error_early_end <= err_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_store) begin
            hdr_q.fields <= s_udp;
        end
        if (save_byte) begin
            last_data <= int_beat.data;
        end
    end

    a_no_input_outside_body: assert property (
        @(posedge clk) disable iff (rst)
        ((state == ST_IDLE) || (state == ST_HEADER)) |-> !s_ready
    ) else $error("payload ready raised before the UDP header went out");

endmodule

`default_nettype wire

// File: axis_skid_buffer.sv
// payload output stage
// registered output with one spare slot so a stalled sink loses nothing,
// plus an early ready that tells the framer it may send next cycle

`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    int_valid,
    input  udp_tx_pkg::axis_beat_t  int_beat,
    output logic                    int_ready_early,

    output logic                    m_valid,
    input  logic                    m_ready,
    output udp_tx_pkg::axis_beat_t  m_beat
);

    import udp_tx_pkg::*;

    axis_beat_t temp_beat;
    logic       temp_valid;

    // room next cycle if the sink drains, both slots are free, or the
    // spare slot is free and nothing lands in it now
    assign int_ready_early = m_ready
                           || (!temp_valid && !m_valid)
                           || (!temp_valid && !int_valid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_valid    <= 1'b0;
            temp_valid <= 1'b0;
        end else if (m_ready || !m_valid) begin
            if (temp_valid) begin
                m_valid    <= 1'b1;
                temp_valid <= 1'b0;
            end else begin
                m_valid <= int_valid;
            end
        end else if (int_valid) begin
            // sink stalled, park beat in spare slot
            temp_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (m_ready || !m_valid) begin
            if (temp_valid) begin
                m_beat <= temp_beat;
            end else if (int_valid) begin
                m_beat <= int_beat;
            end
        end else if (int_valid) begin
            temp_beat <= int_beat;
        end
    end

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
    ) else $error("output beat changed while stalled");

endmodule

`default_nettype wire

// File: udp_ip_tx.sv
// UDP to IP transmit framer
// takes UDP header fields and a payload stream, returns the IP header
// and an IP payload stream led by the serialized UDP header

`timescale 1ns/1ps
`default_nettype none

module udp_ip_tx (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  udp_tx_pkg::ip_fields_t  s_ip,
    input  udp_tx_pkg::udp_hdr_t    s_udp,

    input  logic                    s_valid,
    output logic                    s_ready,
    input  udp_tx_pkg::axis_beat_t  s_beat,

    output logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    output udp_tx_pkg::ip_hdr_t     m_ip,

    output logic                    m_valid,
    input  logic                    m_ready,
    output udp_tx_pkg::axis_beat_t  m_beat,

    output logic                    busy,
    output logic                    error_early_end
);

    import udp_tx_pkg::*;

    logic       hdr_store;
    logic       hdr_pending;
    logic       int_valid;
    logic       int_ready_early;
    axis_beat_t int_beat;

    ip_hdr_reg u_ip_hdr_reg (
        .clk          (clk),
        .rst          (rst),
        .hdr_store    (hdr_store),
        .s_ip         (s_ip),
        .s_udp_length (s_udp.length),
        .m_hdr_valid  (m_hdr_valid),
        .m_hdr_ready  (m_hdr_ready),
        .m_ip         (m_ip),
        .hdr_pending  (hdr_pending)
    );

    udp_tx_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_udp           (s_udp),
        .s_valid         (s_valid),
        .s_ready         (s_ready),
        .s_beat          (s_beat),
        .hdr_store       (hdr_store),
        .hdr_pending     (hdr_pending),
        .int_valid       (int_valid),
        .int_beat        (int_beat),
        .int_ready_early (int_ready_early),
        .busy            (busy),
        .error_early_end (error_early_end)
    );

    axis_skid_buffer u_skid (
        .clk             (clk),
        .rst             (rst),
        .int_valid       (int_valid),
        .int_beat        (int_beat),
        .int_ready_early (int_ready_early),
        .m_valid         (m_valid),
        .m_ready         (m_ready),
        .m_beat          (m_beat)
    );

endmodule

`default_nettype wire

// File: tb_udp_ip_tx.sv
// testbench for the UDP to IP transmit framer
// replays frames from the test file, optionally under random back-pressure,
// and checks the IP header, the output byte stream and the status outputs

`timescale 1ns/1ps
`default_nettype none

module tb_udp_ip_tx;

    import udp_tx_pkg::*;

    localparam int MAX_TESTS = 64;
    localparam int CMP_W     = 192;
    // UDP header size, and the IP header size added to form the total length
    localparam int HDR_BYTES    = 8;
    localparam int IP_HDR_BYTES = 20;

    logic       clk = 1'b0;
    logic       rst;
    logic       s_hdr_valid;
    logic       s_hdr_ready;
    ip_fields_t s_ip;
    udp_hdr_t   s_udp;
    logic       s_valid;
    logic       s_ready;
    axis_beat_t s_beat;
    logic       m_hdr_valid;
    logic       m_hdr_ready = 1'b0;
    ip_hdr_t    m_ip;
    logic       m_valid;
    logic       m_ready = 1'b0;
    axis_beat_t m_beat;
    logic       busy;
    logic       error_early_end;

    // test table as loaded from the file
    logic [8*32-1:0] t_name [MAX_TESTS];
    ip_fields_t      t_ip   [MAX_TESTS];
    udp_hdr_t        t_udp  [MAX_TESTS];
    int              t_plen [MAX_TESTS];
    logic [7:0]      t_seed [MAX_TESTS];
    logic            t_bp   [MAX_TESTS];
    int              num_tests = 0;

    // frame under test
    logic [8*32-1:0] cur_name;
    ip_fields_t      cur_ip;
    udp_hdr_t        cur_udp;
    int              cur_plen;
    logic [7:0]      cur_seed;
    logic            exp_short;
    logic [7:0]      exp_bytes [$];

    logic        bp_on = 1'b0;
    logic [31:0] rnd_word;
    integer      seed = 88102;
    int          errors = 0;
    int          checks = 0;
    int          watchdog_cycles = 0;

    udp_ip_tx dut (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_ip            (s_ip),
        .s_udp           (s_udp),
        .s_valid         (s_valid),
        .s_ready         (s_ready),
        .s_beat          (s_beat),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_ip            (m_ip),
        .m_valid         (m_valid),
        .m_ready         (m_ready),
        .m_beat          (m_beat),
        .busy            (busy),
        .error_early_end (error_early_end)
    );

    always #4 clk = ~clk;

    // sink readiness is random only in back-pressure frames
    always @(posedge clk) begin
        rnd_word = $random(seed);
        if (bp_on) begin
            m_ready     <= rnd_word[0];
            m_hdr_ready <= rnd_word[1];
        end else begin
            m_ready     <= 1'b1;
            m_hdr_ready <= 1'b1;
        end
    end

    task automatic check_value(input string what, input logic [CMP_W-1:0] expected,
                               input logic [CMP_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0s %0s expected %0h actual %0h", cur_name, what, expected, actual);
        end
    endtask

    task automatic load_tests();
        integer          fd;
        integer          n;
        string           line;
        logic [8*32-1:0] nm;
        logic [31:0]     col [19];
        ip_fields_t      ip;
        udp_hdr_t        udp;
        fd = $fopen("udp_tx_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the test file udp_tx_tests.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %d %h %d",
                        nm, col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                        col[16], col[17], col[18]);
            if (n != 20 || num_tests == MAX_TESTS) begin
                $display("ERROR: test file line is malformed or the table is full: %0s", line);
                errors++;
            end else begin
                ip = '{col[0][3:0], col[1][3:0], col[2][5:0], col[3][1:0], col[4][15:0],
                       col[5][2:0], col[6][12:0], col[7][7:0], col[8][7:0], col[9][15:0],
                       col[10], col[11]};
                udp = '{col[12][15:0], col[13][15:0], col[14][15:0], col[15][15:0]};
                t_name[num_tests] = nm;
                t_ip[num_tests]   = ip;
                t_udp[num_tests]  = udp;
                t_plen[num_tests] = int'(col[16]);
                t_seed[num_tests] = col[17][7:0];
                t_bp[num_tests]   = col[18][0];
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_header();
        s_hdr_valid <= 1'b1;
        s_ip        <= cur_ip;
        s_udp       <= cur_udp;
        do begin
            @(posedge clk);
        end while (!(s_hdr_valid && s_hdr_ready));
        s_hdr_valid <= 1'b0;
        // framer is busy from the cycle after the header accept
        @(posedge clk);
        check_value("busy after header accept", CMP_W'(1'b1), CMP_W'(busy));
    endtask

    // payload byte i is seed plus i modulo 256
    task automatic feed_payload();
        int i;
        for (i = 0; i < cur_plen; i++) begin
            s_valid     <= 1'b1;
            s_beat.data <= 8'(cur_seed + i);
            s_beat.last <= (i == cur_plen - 1);
            s_beat.user <= 1'b0;
            do begin
                @(posedge clk);
            end while (!s_ready);
        end
        s_valid <= 1'b0;
        s_beat  <= '0;
    endtask

    task automatic watch_header();
        ip_hdr_t exp_hdr;
        exp_hdr.fields    = cur_ip;
        exp_hdr.ip_length = cur_udp.length + 16'(IP_HDR_BYTES);
        do begin
            @(posedge clk);
        end while (!(m_hdr_valid && m_hdr_ready));
        check_value("ip fields", CMP_W'(exp_hdr.fields), CMP_W'(m_ip.fields));
        check_value("ip_length", CMP_W'(exp_hdr.ip_length), CMP_W'(m_ip.ip_length));
    endtask

    task automatic watch_stream();
        int   idx;
        int   pulses;
        logic done;
        logic exp_last;
        idx    = 0;
        pulses = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (error_early_end) begin
                pulses++;
            end
            if (m_valid && m_ready) begin
                exp_last = (idx == exp_bytes.size() - 1);
                check_value($sformatf("byte %0d data", idx), CMP_W'(exp_bytes[idx]),
                            CMP_W'(m_beat.data));
                check_value($sformatf("byte %0d last", idx), CMP_W'(exp_last),
                            CMP_W'(m_beat.last));
                check_value($sformatf("byte %0d user", idx), CMP_W'(exp_last && exp_short),
                            CMP_W'(m_beat.user));
                idx++;
                done = m_beat.last || (idx == exp_bytes.size());
            end
        end
        check_value("early end pulses", CMP_W'(exp_short), CMP_W'(pulses));
    endtask

    task automatic run_frame(input int idx);
        int keep;
        int i;
        cur_name  = t_name[idx];
        cur_ip    = t_ip[idx];
        cur_udp   = t_udp[idx];
        cur_plen  = t_plen[idx];
        cur_seed  = t_seed[idx];
        bp_on    <= t_bp[idx];
        // UDP length counts the eight header bytes
        keep      = int'(cur_udp.length) - HDR_BYTES;
        exp_short = cur_plen < keep;
        if (cur_plen < keep) begin
            keep = cur_plen;
        end
        exp_bytes.delete();
        exp_bytes.push_back(cur_udp.source_port[15:8]);
        exp_bytes.push_back(cur_udp.source_port[7:0]);
        exp_bytes.push_back(cur_udp.dest_port[15:8]);
        exp_bytes.push_back(cur_udp.dest_port[7:0]);
        exp_bytes.push_back(cur_udp.length[15:8]);
        exp_bytes.push_back(cur_udp.length[7:0]);
        exp_bytes.push_back(cur_udp.checksum[15:8]);
        exp_bytes.push_back(cur_udp.checksum[7:0]);
        for (i = 0; i < keep; i++) begin
            exp_bytes.push_back(8'(cur_seed + i));
        end
        fork
            drive_header();
            feed_payload();
            watch_header();
            watch_stream();
        join
        @(posedge clk);
        check_value("busy after frame", CMP_W'(1'b0), CMP_W'(busy));
        check_value("header valid after frame", CMP_W'(1'b0), CMP_W'(m_hdr_valid));
        repeat (2) @(posedge clk);
    endtask

    // limit scales with the bytes of all frames
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int t;
        int total;
        rst         = 1'b1;
        s_hdr_valid = 1'b0;
        s_ip        = '0;
        s_udp       = '0;
        s_valid     = 1'b0;
        s_beat      = '0;
        load_tests();
        if (num_tests == 0) begin
            $display("ERROR: no tests were loaded");
            errors++;
        end
        total = 0;
        for (t = 0; t < num_tests; t++) begin
            total += HDR_BYTES + t_plen[t];
        end
        watchdog_cycles = 200 * total + 1000;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        for (t = 0; t < num_tests; t++) begin
            run_frame(t);
        end
        $display("tests: %0d  checks: %0d  errors: %0d", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_tx_tests.txt
# name ver ihl dscp ecn ident flags frag ttl proto ip_csum src_ip dst_ip src_port dst_port
# udp_len(dec) udp_csum pay_len(dec) pay_seed bp(1 = random back-pressure), other values hex
exact_one        4 5 00 0 1a2b 2 0000 40 11 b1c2 c0a80001 c0a80002 1234 5678   9 abcd   1 10 0
exact_mid        4 5 2e 1 0001 0 0000 40 11 0000 0a000001 0a0000fe 0400 0035  40 9c3e  32 f0 0
exact_long       4 5 00 0 7777 2 0000 80 11 55aa ac100001 ac1000ff c350 c351 136 0000 128 00 0
long_one         4 5 00 0 0002 2 0000 40 11 1111 c0a80101 c0a80102 0007 0007   9 0f0f   5 a5 0
long_mid         4 5 0a 2 0003 0 0000 20 11 2222 0a0a0a0a 0b0b0b0b 1f90 0050  24 1357  40 33 0
long_by_one      4 5 00 0 0004 2 0000 40 11 3333 7f000001 7f000001 8000 8001  20 2468  13 01 0
short_one        4 5 00 0 0005 2 0000 40 11 4444 c0a80003 c0a80004 2000 2001  40 fedc   1 77 0
short_mid        4 5 3f 3 0006 2 0000 ff 11 5555 01020304 05060708 abcd ef01 100 0001  60 c8 0
short_by_one     4 5 00 0 0007 2 0000 40 11 6666 c0a80005 c0a80006 3000 3001  20 1010  11 e0 0
fields_max       f f 3f 3 ffff 7 1fff ff ff ffff ffffffff ffffffff ffff ffff  16 ffff   8 ff 0
fields_zero      0 0 00 0 0000 0 0000 00 00 0000 00000000 00000000 0000 0000  12 0000   4 00 0
bp_exact_one     4 5 00 0 0101 2 0000 40 11 0a0a c0a80a01 c0a80a02 1000 2000   9 1212   1 fe 1
bp_exact_mid     4 5 12 0 0102 2 0000 40 11 0b0b c0a80a03 c0a80a04 1001 2001  72 3434  64 40 1
bp_exact_big     4 5 00 0 0103 2 0000 40 11 0c0c c0a80a05 c0a80a06 1002 2002 264 5656 256 00 1
bp_exact_wrap    4 5 00 1 0104 0 0000 3c 11 0d0d c0a80a07 c0a80a08 1003 2003 108 7878 100 9c 1
bp_long_one      4 5 00 0 0105 2 0000 40 11 0e0e c0a80a09 c0a80a0a 1004 2004   9 9a9a   6 80 1
bp_long_mid      4 5 00 0 0106 2 0000 40 11 0f0f c0a80a0b c0a80a0c 1005 2005  30 bcbc  50 11 1
bp_long_big      4 5 00 0 0107 2 0000 40 11 1010 c0a80a0d c0a80a0e 1006 2006  50 dede 200 c0 1
bp_long_by_one   4 5 00 0 0108 2 0000 40 11 1111 c0a80a0f c0a80a10 1007 2007  20 f0f0  13 5a 1
bp_short_one     4 5 00 0 0109 2 0000 40 11 1212 c0a80a11 c0a80a12 1008 2008  40 0101   1 3c 1
bp_short_mid     4 5 00 0 010a 2 0000 40 11 1313 c0a80a13 c0a80a14 1009 2009  64 2323  20 d0 1
bp_short_big     4 5 00 0 010b 2 0000 40 11 1414 c0a80a15 c0a80a16 100a 200a 300 4545 150 f8 1
bp_short_by_one  4 5 00 0 010c 2 0000 40 11 1515 c0a80a17 c0a80a18 100b 200b  20 6767  11 02 1
bp_fields_alt    a 9 15 1 5a5a 5 0a5a 3c 06 a5a5 a5a5a5a5 5a5a5a5a 5a5a a5a5  33 c3c3  25 6b 1

// File: vlog.f
+incdir+.
udp_tx_pkg.sv
ip_hdr_reg.sv
udp_tx_ctrl.sv
axis_skid_buffer.sv
udp_ip_tx.sv
tb_udp_ip_tx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the UDP framer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_udp_ip_tx -o tb_udp_ip_tx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_udp_ip_tx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
